// ==== logic/cmd_parser.sv ====
`timescale 1ns/100ps

module cmd_parser
    import spi_cmd_pkg::*;
#(
    parameter int RAM_DEPTH = 64
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  byte_t    rx_byte,
    input  logic     byte_begin,
    input  logic     byte_end,
    input  logic     frame_active,
    output byte_t    tx_byte,
    output reg_cmd_t reg_cmd,
    output byte_t    rd_addr,
    input  word_t    rd_data,
    output ram_req_t ram_req,
    input  word_t    ram_rdata
);

    typedef enum logic [3:0] {
        s_idle,
        s_opcode,
        s_wait,
        s_reg_addr,
        s_reg_hi,
        s_reg_lo,
        s_burst_addr,
        s_burst_cnt_hi,
        s_burst_cnt_lo,
        s_burst_set,
        s_burst_hi,
        s_burst_lo
    } state_e;

    state_e      state;
    logic        op_wr;
    logic        en_set_q;
    logic        en_clr_q;
    logic        ram_we;
    burst_addr_t ram_addr;
    word_t       ram_wdata;
    burst_addr_t burst_addr;
    count_t      burst_cnt;
    byte_t       reg_addr;
    byte_t       data_hi;
    word_t       data_reg;
    logic        in_range;

    assign in_range = (burst_addr < RAM_DEPTH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= s_idle;
            op_wr      <= 1'b0;
            en_set_q   <= 1'b0;
            en_clr_q   <= 1'b0;
            ram_we     <= 1'b0;
            ram_addr   <= '0;
            burst_addr <= '0;
            burst_cnt  <= '0;
        end else begin
            en_set_q <= 1'b0;
            en_clr_q <= 1'b0;
            ram_we   <= 1'b0;
            // select high ends any command, finished or not
            if (!frame_active) begin
                state <= s_idle;
            end else begin
                case (state)
                    s_idle: begin
                        if (byte_begin)
                            state <= s_opcode;
                    end
                    s_opcode: begin
                        if (byte_end) begin
                            case (opcode_e'(rx_byte))
                                op_disable: begin
                                    en_clr_q <= 1'b1;
                                    state    <= s_wait;
                                end
                                op_enable: begin
                                    en_set_q <= 1'b1;
                                    state    <= s_wait;
                                end
                                op_wr_reg,
                                op_rd_reg: begin
                                    op_wr <= (rx_byte == op_wr_reg);
                                    state <= s_reg_addr;
                                end
                                op_wr_ram,
                                op_rd_ram: begin
                                    op_wr <= (rx_byte == op_wr_ram);
                                    state <= s_burst_addr;
                                end
                                // unknown opcode, ignore rest of frame
                                default: state <= s_wait;
                            endcase
                        end
                    end
                    s_reg_addr: begin
                        if (byte_end)
                            state <= s_reg_hi;
                    end
                    s_reg_hi: begin
                        if (byte_end)
                            state <= s_reg_lo;
                    end
                    s_reg_lo: begin
                        if (byte_end)
                            state <= s_wait;
                    end
                    s_burst_addr: begin
                        if (byte_end) begin
                            burst_addr <= {8'h00, rx_byte};
                            ram_addr   <= {8'h00, rx_byte};
                            state      <= s_burst_cnt_hi;
                        end
                    end
                    s_burst_cnt_hi: begin
                        if (byte_end) begin
                            burst_cnt[15:8] <= rx_byte;
                            state           <= s_burst_cnt_lo;
                        end
                    end
                    s_burst_cnt_lo: begin
                        if (byte_end) begin
                            burst_cnt[7:0] <= rx_byte;
                            if ({burst_cnt[15:8], rx_byte} == 16'd0)
                                state <= s_wait;
                            else
                                state <= s_burst_set;
                        end
                    end
                    // present word address, high byte slot starts here
                    s_burst_set: begin
                        ram_addr <= burst_addr;
                        if (byte_begin)
                            state <= s_burst_hi;
                    end
                    s_burst_hi: begin
                        if (byte_end)
                            state <= s_burst_lo;
                    end
                    s_burst_lo: begin
                        // read: step early so the next word is ready in time
                        if (byte_begin && !op_wr) begin
                            burst_addr <= burst_addr + 16'd1;
                            ram_addr   <= burst_addr + 16'd1;
                        end
                        if (byte_end) begin
                            if (op_wr) begin
                                ram_we     <= in_range;
                                ram_addr   <= burst_addr;
                                burst_addr <= burst_addr + 16'd1;
                            end
                            burst_cnt <= burst_cnt - 16'd1;
                            if (burst_cnt == 16'd1)
                                state <= s_wait;
                            else
                                state <= s_burst_set;
                        end
                    end
                    s_wait: ;
                    default: state <= s_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_end) begin
            case (state)
                s_reg_addr: begin
                    reg_addr <= rx_byte;
                    data_reg <= rd_data;
                end
                s_reg_hi,
                s_burst_hi: data_hi <= rx_byte;
                s_burst_lo: begin
                    if (op_wr)
                        ram_wdata <= {data_hi, rx_byte};
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        tx_byte = '0;
        case (state)
            s_reg_hi: begin
                if (!op_wr)
                    tx_byte = data_reg[15:8];
            end
            s_reg_lo: begin
                if (!op_wr)
                    tx_byte = data_reg[7:0];
            end
            s_burst_set: begin
                if (!op_wr && in_range)
                    tx_byte = ram_rdata[15:8];
            end
            s_burst_lo: begin
                if (!op_wr && in_range)
                    tx_byte = ram_rdata[7:0];
            end
            default: ;
        endcase
    end

    assign rd_addr = rx_byte;

    assign reg_cmd.wr     = (state == s_reg_lo) && op_wr && byte_end;
    assign reg_cmd.addr   = reg_addr;
    assign reg_cmd.data   = {data_hi, rx_byte};
    assign reg_cmd.en_set = en_set_q;
    assign reg_cmd.en_clr = en_clr_q;

    assign ram_req.we    = ram_we;
    assign ram_req.addr  = ram_addr;
    assign ram_req.wdata = ram_wdata;

    // keeps word_ram from ever seeing a write past its end
    a_ram_we_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) ram_req.we |-> (ram_req.addr < RAM_DEPTH)
    );

endmodule

// ==== logic/ctrl_regs.sv ====
`timescale 1ns/100ps

module ctrl_regs
    import spi_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_cmd_t  reg_cmd,
    input  byte_t     rd_addr,
    output word_t     rd_data,
    input  word_t     sum,
    output num_regs_t nums,
    output logic      en
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nums <= '0;
            en   <= 1'b0;
        end else begin
            // sum and en are not writable through the register path
            if (reg_cmd.wr) begin
                case (reg_addr_e'(reg_cmd.addr))
                    reg_num1: nums.num1 <= reg_cmd.data;
                    reg_num2: nums.num2 <= reg_cmd.data;
                    reg_num3: nums.num3 <= reg_cmd.data;
                    default: ;
                endcase
            end
            if (reg_cmd.en_set)
                en <= 1'b1;
            else if (reg_cmd.en_clr)
                en <= 1'b0;
        end
    end

    always_comb begin
        case (reg_addr_e'(rd_addr))
            reg_sum:  rd_data = sum;
            reg_num1: rd_data = nums.num1;
            reg_num2: rd_data = nums.num2;
            reg_num3: rd_data = nums.num3;
            reg_en:   rd_data = word_t'(en);
            default:  rd_data = '0;
        endcase
    end

    // enable and disable come from different opcodes
    a_en_strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(reg_cmd.en_set && reg_cmd.en_clr)
    );

endmodule

// ==== logic/spi_byte_slave.sv ====
`timescale 1ns/100ps

module spi_byte_slave
    import spi_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  spi_pins_t pins,
    input  byte_t     tx_byte,
    output logic      sdo,
    output byte_t     rx_byte,
    output logic      byte_begin,
    output logic      byte_end,
    output logic      frame_active
);

    localparam spi_pins_t PINS_IDLE = '{scl: 1'b0, sdi: 1'b0, sel: 1'b1};

    spi_pins_t  pins_s1;
    spi_pins_t  pins_s2;
    spi_pins_t  pins_d;
    logic [2:0] bit_cnt;
    byte_t      rx_shift;
    byte_t      tx_shift;
    logic       scl_rise;
    logic       scl_fall;
    logic       sel_fall;

    // two-flop synchronizer, then one more stage for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pins_s1 <= PINS_IDLE;
            pins_s2 <= PINS_IDLE;
            pins_d  <= PINS_IDLE;
        end else begin
            pins_s1 <= pins;
            pins_s2 <= pins_s1;
            pins_d  <= pins_s2;
        end
    end

    assign scl_rise     = pins_s2.scl & ~pins_d.scl;
    assign scl_fall     = ~pins_s2.scl & pins_d.scl;
    assign sel_fall     = ~pins_s2.sel & pins_d.sel;
    assign frame_active = ~pins_s2.sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= 3'd0;
            byte_begin <= 1'b0;
            byte_end   <= 1'b0;
        end else begin
            byte_end   <= 1'b0;
            // next byte starts right after the previous one ends
            byte_begin <= sel_fall | (byte_end & frame_active);
            if (!frame_active) begin
                bit_cnt <= 3'd0;
            end else if (scl_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    byte_end <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_active && scl_rise) begin
            rx_shift <= {rx_shift[6:0], pins_s2.sdi};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {rx_shift[6:0], pins_s2.sdi};
            end
        end
    end

    // mode 0: shift out on falling edges, but not the trailing fall of a byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= '0;
        end else if (!frame_active) begin
            tx_shift <= '0;
        end else if (byte_begin) begin
            tx_shift <= tx_byte;
        end else if (scl_fall && bit_cnt != 3'd0) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign sdo = tx_shift[7];

    a_begin_end_apart: assert property (
        @(posedge clk) disable iff (!rst_n) !(byte_begin && byte_end)
    );

endmodule

// ==== logic/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [15:0] count_t;
    // wide enough to run past the end of the RAM
    typedef logic [15:0] burst_addr_t;

    typedef enum logic [7:0] {
        op_disable = 8'h00,
        op_enable  = 8'h01,
        op_wr_reg  = 8'h02,
        op_rd_reg  = 8'h03,
        op_wr_ram  = 8'h06,
        op_rd_ram  = 8'h07
    } opcode_e;

    typedef enum logic [7:0] {
        reg_sum  = 8'd0,
        reg_num1 = 8'd1,
        reg_num2 = 8'd2,
        reg_num3 = 8'd3,
        reg_en   = 8'd4
    } reg_addr_e;

    typedef struct packed {
        logic scl;
        logic sdi;
        logic sel;
    } spi_pins_t;

    typedef struct packed {
        logic  wr;
        byte_t addr;
        word_t data;
        logic  en_set;
        logic  en_clr;
    } reg_cmd_t;

    typedef struct packed {
        logic        we;
        burst_addr_t addr;
        word_t       wdata;
    } ram_req_t;

    typedef struct packed {
        word_t num1;
        word_t num2;
        word_t num3;
    } num_regs_t;

endpackage

// ==== logic/spi_cmd_top.sv ====
`timescale 1ns/100ps

module spi_cmd_top
    import spi_cmd_pkg::*;
#(
    parameter int RAM_DEPTH = 64
)
(
    input  logic      clk,
    input  logic      rst_n,
    input  spi_pins_t pins,
    output logic      sdo,
    input  word_t     sum,
    output num_regs_t nums,
    output logic      en
);

    byte_t    rx_byte;
    byte_t    tx_byte;
    logic     byte_begin;
    logic     byte_end;
    logic     frame_active;
    reg_cmd_t reg_cmd;
    byte_t    rd_addr;
    word_t    rd_data;
    ram_req_t ram_req;
    word_t    ram_rdata;

    spi_byte_slave u_slave (
        .clk          (clk),
        .rst_n        (rst_n),
        .pins         (pins),
        .tx_byte      (tx_byte),
        .sdo          (sdo),
        .rx_byte      (rx_byte),
        .byte_begin   (byte_begin),
        .byte_end     (byte_end),
        .frame_active (frame_active)
    );

    cmd_parser #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_byte      (rx_byte),
        .byte_begin   (byte_begin),
        .byte_end     (byte_end),
        .frame_active (frame_active),
        .tx_byte      (tx_byte),
        .reg_cmd      (reg_cmd),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .ram_req      (ram_req),
        .ram_rdata    (ram_rdata)
    );

    ctrl_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .reg_cmd (reg_cmd),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .sum     (sum),
        .nums    (nums),
        .en      (en)
    );

    word_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_ram (
        .clk   (clk),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

endmodule

// ==== logic/word_ram.sv ====
`timescale 1ns/100ps

module word_ram
    import spi_cmd_pkg::*;
#(
    parameter int RAM_DEPTH = 64
)
(
    input  logic     clk,
    input  ram_req_t req,
    output word_t    rdata
);

    localparam int AW = $clog2(RAM_DEPTH);

    word_t         mem [RAM_DEPTH];
    logic [AW-1:0] idx;

    // upper address bits dropped here, range is checked by the parser
    assign idx = req.addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (req.we)
            mem[idx] <= req.wdata;
        rdata <= mem[idx];
    end

endmodule

// ==== project.f ====
+incdir+include
logic/spi_cmd_pkg.sv
logic/spi_byte_slave.sv
logic/cmd_parser.sv
logic/ctrl_regs.sv
logic/word_ram.sv
logic/spi_cmd_top.sv
tb/tb_spi_cmd_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_cmd_top \
    -f project.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== include/spi_host_tasks.svh ====
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// SPI host side, mode 0, MSB first
// every task is entered and left just after a rising clk edge

task automatic shift_byte(input byte_t tx, output byte_t rx);
    int i;
    for (i = 7; i >= 0; i--) begin
        pins.sdi <= tx[i];
        repeat (HALF_CLK) @(posedge clk);
        pins.scl <= 1'b1;
        // sdo moved a few clk after the last falling edge
        rx[i] = sdo;
        repeat (HALF_CLK) @(posedge clk);
        pins.scl <= 1'b0;
    end
endtask

// sends tx_q as one frame, received bytes land in rx_q
task automatic run_frame();
    byte_t rx;
    // one quiet edge between frames, outputs are compared there
    @(posedge clk);
    bus_quiet <= 1'b0;
    pins.sel  <= 1'b0;
    rx_q.delete();
    // slave needs a few clk to load its first byte
    repeat (2 * HALF_CLK) @(posedge clk);
    foreach (tx_q[i]) begin
        shift_byte(tx_q[i], rx);
        rx_q.push_back(rx);
    end
    repeat (HALF_CLK) @(posedge clk);
    pins.sel <= 1'b1;
    repeat (4 * HALF_CLK) @(posedge clk);
    bus_quiet <= 1'b1;
    tx_q.delete();
endtask

task automatic send_command(input byte_t op);
    tx_q.push_back(op);
    run_frame();
endtask

task automatic write_reg(input byte_t addr, input word_t data);
    tx_q.push_back(8'h02);
    tx_q.push_back(addr);
    tx_q.push_back(data[15:8]);
    tx_q.push_back(data[7:0]);
    run_frame();
endtask

task automatic read_reg(input byte_t addr, output word_t data);
    tx_q.push_back(8'h03);
    tx_q.push_back(addr);
    tx_q.push_back(8'h00);
    tx_q.push_back(8'h00);
    run_frame();
    data = {rx_q[2], rx_q[3]};
endtask

// words come from burst_buf
task automatic write_burst(input int start);
    count_t cnt;
    cnt = count_t'(burst_buf.size());
    tx_q.push_back(8'h06);
    tx_q.push_back(byte_t'(start));
    tx_q.push_back(cnt[15:8]);
    tx_q.push_back(cnt[7:0]);
    foreach (burst_buf[i]) begin
        tx_q.push_back(burst_buf[i][15:8]);
        tx_q.push_back(burst_buf[i][7:0]);
    end
    run_frame();
endtask

// words read back are left in burst_buf
task automatic read_burst(input int start, input int count);
    count_t cnt;
    int     i;
    cnt = count_t'(count);
    tx_q.push_back(8'h07);
    tx_q.push_back(byte_t'(start));
    tx_q.push_back(cnt[15:8]);
    tx_q.push_back(cnt[7:0]);
    repeat (2 * count) tx_q.push_back(8'h00);
    run_frame();
    burst_buf.delete();
    for (i = 0; i < count; i++) begin
        burst_buf.push_back({rx_q[4 + 2 * i], rx_q[5 + 2 * i]});
    end
endtask

`endif

// ==== tb/tb_spi_cmd_top.sv ====
`timescale 1ns/100ps

module tb_spi_cmd_top
    import spi_cmd_pkg::*;
();

    localparam int RAM_DEPTH = 64;
    localparam int CLK_NS    = 20;
    localparam int HALF_CLK  = 4;
    localparam int BURST_LEN = 8;
    // totals over all scenarios below
    localparam int TEST_BYTES  = 215;
    localparam int TEST_FRAMES = 33;
    // 8 bits per byte, 2 half periods per bit, plus select overhead per frame
    localparam longint TIMEOUT_NS = longint'(TEST_BYTES) * 8 * 2 * HALF_CLK * CLK_NS
                                  + longint'(TEST_FRAMES) * 8 * HALF_CLK * CLK_NS + 20000;
    localparam byte_t REG_ADDRS [7] = '{8'd1, 8'd2, 8'd3, 8'd0, 8'd4, 8'd9, 8'd200};

    logic      clk = 1'b0;
    logic      rst_n;
    spi_pins_t pins;
    logic      sdo;
    word_t     sum;
    num_regs_t nums;
    logic      en;

    byte_t     tx_q[$];
    byte_t     rx_q[$];
    word_t     burst_buf[$];
    logic      bus_quiet;
    num_regs_t model_nums;
    logic      model_en;
    word_t     model_ram [RAM_DEPTH];
    int        seed;
    int        read_errors;
    int        state_errors;

    always #(CLK_NS / 2) clk = ~clk;

    spi_cmd_top #(
        .RAM_DEPTH (RAM_DEPTH)
    ) UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .pins  (pins),
        .sdo   (sdo),
        .sum   (sum),
        .nums  (nums),
        .en    (en)
    );

    `include "spi_host_tasks.svh"

    // bus idle, so outputs must agree with the register model
    a_outputs_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus_quiet |-> (nums == model_nums && en == model_en)
    ) else begin
        state_errors++;
        $display("MISMATCH at %0t: nums %h en %b, model nums %h en %b",
                 $time, nums, en, model_nums, model_en);
    end

    a_sdo_idle: assert property (
        @(posedge clk) disable iff (!rst_n) bus_quiet |-> !sdo
    ) else begin
        state_errors++;
        $display("MISMATCH at %0t: sdo high while select is inactive", $time);
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            read_errors++;
            $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    // only num1 to num3 take writes
    function automatic void apply_reg_write(input byte_t addr, input word_t data);
        case (addr)
            8'd1: model_nums.num1 = data;
            8'd2: model_nums.num2 = data;
            8'd3: model_nums.num3 = data;
            default: ;
        endcase
    endfunction

    function automatic word_t reg_value(input byte_t addr);
        case (addr)
            8'd0: return sum;
            8'd1: return model_nums.num1;
            8'd2: return model_nums.num2;
            8'd3: return model_nums.num3;
            8'd4: return {15'd0, model_en};
            default: return 16'h0000;
        endcase
    endfunction

    function automatic void fill_random(input int count);
        burst_buf.delete();
        repeat (count) burst_buf.push_back(word_t'($random(seed)));
    endfunction

    function automatic void apply_burst(input int start);
        foreach (burst_buf[i]) begin
            if (start + i < RAM_DEPTH)
                model_ram[start + i] = burst_buf[i];
        end
    endfunction

    function automatic word_t ram_value(input int addr);
        return (addr < RAM_DEPTH) ? model_ram[addr] : 16'h0000;
    endfunction

    task automatic verify_burst(input int start, input int count);
        read_burst(start, count);
        foreach (burst_buf[i]) begin
            check_word($sformatf("ram[%0d]", start + i), burst_buf[i], ram_value(start + i));
        end
    endtask

    initial begin
        word_t got;
        word_t w;
        int    i;
        int    start;

        seed         = 95;
        read_errors  = 0;
        state_errors = 0;
        model_nums   = '0;
        model_en     = 1'b0;
        rst_n     <= 1'b0;
        pins      <= '{scl: 1'b0, sdi: 1'b0, sel: 1'b1};
        sum       <= word_t'($random(seed));
        bus_quiet <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        bus_quiet <= 1'b1;
        repeat (2) @(posedge clk);

        // reset values
        for (i = 0; i <= 4; i++) begin
            read_reg(byte_t'(i), got);
            check_word($sformatf("reg %0d after reset", i), got, reg_value(byte_t'(i)));
        end

        // enable, then disable
        send_command(8'h01);
        model_en = 1'b1;
        read_reg(8'd4, got);
        check_word("en after enable", got, reg_value(8'd4));
        send_command(8'h00);
        model_en = 1'b0;
        read_reg(8'd4, got);
        check_word("en after disable", got, reg_value(8'd4));

        // writable, read only and unknown addresses
        for (i = 0; i < 6; i++) begin
            w = word_t'($random(seed));
            write_reg(REG_ADDRS[i], w);
            apply_reg_write(REG_ADDRS[i], w);
        end
        for (i = 0; i < 7; i++) begin
            read_reg(REG_ADDRS[i], got);
            check_word($sformatf("reg %0d", REG_ADDRS[i]), got, reg_value(REG_ADDRS[i]));
        end

        // burst inside the RAM
        start = {$random(seed)} % (RAM_DEPTH - BURST_LEN + 1);
        fill_random(BURST_LEN);
        write_burst(start);
        apply_burst(start);
        verify_burst(start, BURST_LEN);

        // low words first, then a burst running past the last word
        fill_random(4);
        write_burst(0);
        apply_burst(0);
        fill_random(6);
        write_burst(RAM_DEPTH - 3);
        apply_burst(RAM_DEPTH - 3);
        verify_burst(RAM_DEPTH - 3, 6);
        verify_burst(0, 4);
        verify_burst(start, BURST_LEN);

        // unknown opcode, the trailing bytes look like a write to num1
        tx_q.push_back(8'h04);
        tx_q.push_back(8'h02);
        tx_q.push_back(8'h01);
        tx_q.push_back(8'hbe);
        tx_q.push_back(8'hef);
        run_frame();
        w = word_t'($random(seed));
        write_reg(8'd2, w);
        apply_reg_write(8'd2, w);
        read_reg(8'd2, got);
        check_word("num2 after unknown opcode", got, reg_value(8'd2));
        read_reg(8'd1, got);
        check_word("num1 after unknown opcode", got, reg_value(8'd1));

        $display("errors: %0d read mismatches, %0d state mismatches",
                 read_errors, state_errors);
        if (read_errors == 0 && state_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: scenarios still running after %0d ns", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
